// File: hw/apb_host_port.sv
`timescale 1ns/1ns
`default_nettype none

module apb_host_port (
	input wire clk_i,
	input wire rst_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [core_pkg::APB_ADDR_W-1:0] paddr_i,
	input wire [core_pkg::XLEN-1:0] pwdata_i,
	output logic [core_pkg::XLEN-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input wire halt_seen_i,
	output logic imem_we_o,
	output logic [core_pkg::IMEM_IDX_W-1:0] imem_addr_o,
	output logic [core_pkg::XLEN-1:0] imem_data_o,
	output logic run_o,
	output logic restart_o,
	output logic [core_pkg::REG_ADDR_W-1:0] dbg_addr_o,
	input wire [core_pkg::XLEN-1:0] dbg_data_i
);
	logic access;
	logic hit_imem;
	logic hit_ctrl;
	logic hit_status;
	logic hit_reg;
	logic err;
	logic halted;

	assign access = psel_i && penable_i;

	// address decode
	assign hit_imem = paddr_i[11:10] == core_pkg::ADDR_IMEM_BASE[11:10];
	assign hit_ctrl = paddr_i == core_pkg::ADDR_CTRL;
	assign hit_status = paddr_i == core_pkg::ADDR_STATUS;
	assign hit_reg = paddr_i[11:6] == core_pkg::ADDR_REG_BASE[11:6];

	assign err = !(hit_imem || hit_ctrl || hit_status || hit_reg)
		|| (hit_imem && (!pwrite_i || run_o)); // imem is write only and locked while running

	assign pready_o = 1'b1;
	assign pslverr_o = access && err;

	assign imem_we_o = access && pwrite_i && hit_imem && !run_o;
	assign imem_addr_o = paddr_i[core_pkg::IMEM_IDX_W+1:2];
	assign imem_data_o = pwdata_i;

	assign restart_o = access && pwrite_i && hit_ctrl && pwdata_i[0];
	assign dbg_addr_o = paddr_i[core_pkg::REG_ADDR_W+1:2];

	always_comb
	begin
		prdata_o = '0;
		if (hit_status)
			prdata_o = {30'h0, halted, run_o};
		else if (hit_reg)
			prdata_o = dbg_data_i;
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			run_o <= 1'b0;
			halted <= 1'b0;
		end
		else if (restart_o)
		begin
			run_o <= 1'b1;
			halted <= 1'b0;
		end
		else if (halt_seen_i)
		begin
			run_o <= 1'b0;
			halted <= 1'b1;
		end
	end
endmodule

`default_nettype wire

// File: hw/core_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fetch_dec_if;
	logic valid;
	logic [core_pkg::XLEN-1:0] ir;
	logic [core_pkg::XLEN-1:0] pc;

	modport fetch (
		output valid,
		output ir,
		output pc
	);

	modport decode (
		input valid,
		input ir,
		input pc
	);
endinterface

interface dec_ex_if;
	logic valid;
	logic [core_pkg::XLEN-1:0] ir;
	logic [core_pkg::XLEN-1:0] op_a;
	logic [core_pkg::XLEN-1:0] op_b;
	logic wr_en;

	modport decode (
		output valid,
		output ir,
		output op_a,
		output op_b,
		output wr_en
	);

	modport execute (
		input valid,
		input ir,
		input op_a,
		input op_b,
		input wr_en
	);
endinterface

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS = 1 << REG_ADDR_W;
	localparam int IMEM_DEPTH = 256;
	localparam int IMEM_IDX_W = $clog2(IMEM_DEPTH);
	localparam int APB_ADDR_W = 12;

	localparam logic [APB_ADDR_W-1:0] ADDR_IMEM_BASE = 12'h000; // instruction words, write only
	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL = 12'h400;
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 12'h404;
	localparam logic [APB_ADDR_W-1:0] ADDR_REG_BASE = 12'h500; // r0..r15, read only

	typedef enum logic [3:0] {
		T_ALU = 4'h0,
		T_LDI = 4'h1,
		T_MOV = 4'h2,
		T_HALT = 4'hf
	} instr_type_e;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_OR = 4'h3,
		OP_XOR = 4'h4
	} alu_op_e;

	// instruction field extraction
	function automatic instr_type_e instr_type(input logic [XLEN-1:0] ir);
		return instr_type_e'(ir[31:28]);
	endfunction

	function automatic alu_op_e instr_op(input logic [XLEN-1:0] ir);
		return alu_op_e'(ir[27:24]);
	endfunction

	function automatic logic [REG_ADDR_W-1:0] instr_ra(input logic [XLEN-1:0] ir);
		return ir[23:20];
	endfunction

	function automatic logic [REG_ADDR_W-1:0] instr_rb(input logic [XLEN-1:0] ir);
		return ir[19:16];
	endfunction

	function automatic logic [REG_ADDR_W-1:0] instr_rc(input logic [XLEN-1:0] ir);
		return ir[15:12];
	endfunction

	function automatic logic [XLEN-1:0] instr_imm(input logic [XLEN-1:0] ir);
		return {16'h0000, ir[15:0]}; // zero extended
	endfunction

endpackage

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top (
	input wire clk_i,
	input wire rst_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [core_pkg::APB_ADDR_W-1:0] paddr_i,
	input wire [core_pkg::XLEN-1:0] pwdata_i,
	output logic [core_pkg::XLEN-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o
);
	logic run;
	logic restart;
	logic halt_seen;
	logic imem_we;
	logic [core_pkg::IMEM_IDX_W-1:0] imem_addr;
	logic [core_pkg::XLEN-1:0] imem_data;
	logic wr_en;
	logic [core_pkg::REG_ADDR_W-1:0] wr_addr;
	logic [core_pkg::XLEN-1:0] wr_data;
	logic [core_pkg::REG_ADDR_W-1:0] dbg_addr;
	logic [core_pkg::XLEN-1:0] dbg_data;

	fetch_dec_if fd_link ();
	dec_ex_if dx_link ();

	apb_host_port i_apb_host_port (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.halt_seen_i(halt_seen),
		.imem_we_o(imem_we),
		.imem_addr_o(imem_addr),
		.imem_data_o(imem_data),
		.run_o(run),
		.restart_o(restart),
		.dbg_addr_o(dbg_addr),
		.dbg_data_i(dbg_data)
	);

	instr_fetch i_instr_fetch (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.run_i(run),
		.restart_i(restart),
		.imem_we_i(imem_we),
		.imem_addr_i(imem_addr),
		.imem_data_i(imem_data),
		.fd_o(fd_link.fetch)
	);

	idecode i_idecode (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.stall_i(!run), // stalled whenever not running
		.flush_i(restart),
		.fd_i(fd_link.decode),
		.dx_o(dx_link.decode),
		.wr_en_i(wr_en),
		.wr_addr_i(wr_addr),
		.wr_data_i(wr_data),
		.dbg_addr_i(dbg_addr),
		.dbg_data_o(dbg_data)
	);

	execute_unit i_execute_unit (
		.stall_i(!run),
		.dx_i(dx_link.execute),
		.wr_en_o(wr_en),
		.wr_addr_o(wr_addr),
		.wr_data_o(wr_data),
		.halt_seen_o(halt_seen)
	);
endmodule

`default_nettype wire

// File: hw/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
	input wire stall_i,
	dec_ex_if.execute dx_i,
	output logic wr_en_o,
	output logic [core_pkg::REG_ADDR_W-1:0] wr_addr_o,
	output logic [core_pkg::XLEN-1:0] wr_data_o,
	output logic halt_seen_o
);
	core_pkg::instr_type_e ir_type;
	core_pkg::alu_op_e alu_op;
	logic [core_pkg::XLEN-1:0] alu_result;
	logic active;

	assign ir_type = core_pkg::instr_type(dx_i.ir);
	assign alu_op = core_pkg::instr_op(dx_i.ir);
	assign active = dx_i.valid && !stall_i;

	always_comb
	begin
		case (alu_op)
			core_pkg::OP_ADD:
				alu_result = dx_i.op_a + dx_i.op_b;
			core_pkg::OP_SUB:
				alu_result = dx_i.op_a - dx_i.op_b;
			core_pkg::OP_AND:
				alu_result = dx_i.op_a & dx_i.op_b;
			core_pkg::OP_OR:
				alu_result = dx_i.op_a | dx_i.op_b;
			core_pkg::OP_XOR:
				alu_result = dx_i.op_a ^ dx_i.op_b;
			default:
				alu_result = '0; // undefined op
		endcase
	end

	// result select
	always_comb
	begin
		case (ir_type)
			core_pkg::T_ALU:
				wr_data_o = alu_result;
			core_pkg::T_MOV:
				wr_data_o = dx_i.op_a;
			core_pkg::T_LDI:
				wr_data_o = core_pkg::instr_imm(dx_i.ir);
			default:
				wr_data_o = '0;
		endcase
	end

	assign wr_en_o = active && dx_i.wr_en;
	assign wr_addr_o = core_pkg::instr_ra(dx_i.ir);
	assign halt_seen_o = active && (ir_type == core_pkg::T_HALT);
endmodule

`default_nettype wire

// File: hw/idecode.sv
`timescale 1ns/1ns
`default_nettype none

module idecode (
	input wire clk_i,
	input wire rst_i,
	input wire stall_i,
	input wire flush_i,
	fetch_dec_if.decode fd_i,
	dec_ex_if.decode dx_o,
	input wire wr_en_i,
	input wire [core_pkg::REG_ADDR_W-1:0] wr_addr_i,
	input wire [core_pkg::XLEN-1:0] wr_data_i,
	input wire [core_pkg::REG_ADDR_W-1:0] dbg_addr_i,
	output logic [core_pkg::XLEN-1:0] dbg_data_o
);
	core_pkg::instr_type_e ir_type;
	logic [core_pkg::REG_ADDR_W-1:0] read1;
	logic [core_pkg::REG_ADDR_W-1:0] read2;
	logic [core_pkg::XLEN-1:0] rf_data1;
	logic [core_pkg::XLEN-1:0] rf_data2;
	logic wr_en_next;

	assign ir_type = core_pkg::instr_type(fd_i.ir);

	// read port selection by type
	always_comb
	begin
		case (ir_type)
			core_pkg::T_ALU:
			begin
				read1 = core_pkg::instr_rb(fd_i.ir);
				read2 = core_pkg::instr_rc(fd_i.ir);
			end
			core_pkg::T_MOV:
			begin
				read1 = core_pkg::instr_rb(fd_i.ir);
				read2 = core_pkg::instr_rb(fd_i.ir);
			end
			default:
			begin
				read1 = '0; // LDI, HALT and no-ops read nothing
				read2 = '0;
			end
		endcase
	end

	always_comb
	begin
		case (ir_type)
			core_pkg::T_ALU,
			core_pkg::T_LDI,
			core_pkg::T_MOV:
				wr_en_next = fd_i.valid;
			default:
				wr_en_next = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			dx_o.valid <= 1'b0;
			dx_o.wr_en <= 1'b0;
		end
		else if (flush_i)
		begin
			dx_o.valid <= 1'b0;
			dx_o.wr_en <= 1'b0;
		end
		else if (!stall_i)
		begin
			dx_o.valid <= fd_i.valid;
			dx_o.wr_en <= wr_en_next;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall_i)
		begin
			dx_o.ir <= fd_i.ir;
			dx_o.op_a <= rf_data1;
			dx_o.op_b <= rf_data2;
		end
	end

	register_file i_register_file (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.read1_i(read1),
		.read2_i(read2),
		.data1_o(rf_data1),
		.data2_o(rf_data2),
		.write_en_i(wr_en_i),
		.write_addr_i(wr_addr_i),
		.write_data_i(wr_data_i),
		.dbg_addr_i(dbg_addr_i),
		.dbg_data_o(dbg_data_o)
	);
endmodule

`default_nettype wire

// File: hw/instr_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module instr_fetch (
	input wire clk_i,
	input wire rst_i,
	input wire run_i,
	input wire restart_i,
	input wire imem_we_i,
	input wire [core_pkg::IMEM_IDX_W-1:0] imem_addr_i,
	input wire [core_pkg::XLEN-1:0] imem_data_i,
	fetch_dec_if.fetch fd_o
);
	logic [core_pkg::XLEN-1:0] imem [core_pkg::IMEM_DEPTH];
	logic [core_pkg::XLEN-1:0] pc;
	logic [core_pkg::IMEM_IDX_W-1:0] pc_idx;
	logic advance;

	assign pc_idx = pc[core_pkg::IMEM_IDX_W+1:2]; // word index
	assign advance = run_i && !restart_i;

	always_ff @(posedge clk_i)
	begin
		if (imem_we_i)
			imem[imem_addr_i] <= imem_data_i;
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			pc <= '0;
			fd_o.valid <= 1'b0;
		end
		else if (restart_i)
		begin
			pc <= '0;
			fd_o.valid <= 1'b0;
		end
		else if (run_i)
		begin
			pc <= pc + 32'd4;
			fd_o.valid <= 1'b1;
		end
	end

	// payload holds while stalled
	always_ff @(posedge clk_i)
	begin
		if (advance)
		begin
			fd_o.ir <= imem[pc_idx];
			fd_o.pc <= pc;
		end
	end
endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input wire clk_i,
	input wire rst_i,
	input wire [core_pkg::REG_ADDR_W-1:0] read1_i,
	input wire [core_pkg::REG_ADDR_W-1:0] read2_i,
	output logic [core_pkg::XLEN-1:0] data1_o,
	output logic [core_pkg::XLEN-1:0] data2_o,
	input wire write_en_i,
	input wire [core_pkg::REG_ADDR_W-1:0] write_addr_i,
	input wire [core_pkg::XLEN-1:0] write_data_i,
	input wire [core_pkg::REG_ADDR_W-1:0] dbg_addr_i,
	output logic [core_pkg::XLEN-1:0] dbg_data_o
);
	logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];
	logic hit1;
	logic hit2;
	logic hit_dbg;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < core_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (write_en_i)
			regs[write_addr_i] <= write_data_i;
	end

	// same-cycle write is visible on every read port
	assign hit1 = write_en_i && (write_addr_i == read1_i);
	assign hit2 = write_en_i && (write_addr_i == read2_i);
	assign hit_dbg = write_en_i && (write_addr_i == dbg_addr_i);

	assign data1_o = hit1 ? write_data_i : regs[read1_i];
	assign data2_o = hit2 ? write_data_i : regs[read2_i];
	assign dbg_data_o = hit_dbg ? write_data_i : regs[dbg_addr_i];
endmodule

`default_nettype wire

// File: tb.f
hw/core_pkg.sv
hw/core_if.sv
hw/apb_host_port.sv
hw/instr_fetch.sv
hw/register_file.sv
hw/idecode.sv
hw/execute_unit.sv
hw/core_top.sv
verification/core_properties.sv
verification/core_tb.sv

// File: verification/core_properties.sv
`timescale 1ns/1ns
`default_nettype none

module core_properties (
	input wire clk_i,
	input wire rst_i,
	input wire psel_i,
	input wire penable_i,
	input wire pready_i,
	input wire pslverr_i,
	input wire run_i,
	input wire wr_en_i,
	input wire halted_i
);
	int fail_count = 0; // read by the testbench at the end

	a_pslverr_access: assert property (@(posedge clk_i) disable iff (rst_i)
		pslverr_i |-> (psel_i && penable_i))
	else
	begin
		$error("pslverr outside an access phase");
		fail_count++;
	end

	a_pready_access: assert property (@(posedge clk_i) disable iff (rst_i)
		(psel_i && penable_i) |-> pready_i)
	else
	begin
		$error("pready low in an access phase");
		fail_count++;
	end

	a_no_write_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
		!run_i |-> !wr_en_i) // stall is !run
	else
	begin
		$error("register write while stalled");
		fail_count++;
	end

	a_run_halt_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
		!(halted_i && run_i))
	else
	begin
		$error("running and halted both set");
		fail_count++;
	end
endmodule

`default_nettype wire

// File: verification/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;
	localparam logic [31:0] HALT_WORD = 32'hf000_0000;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	wire [31:0] prdata;
	wire pready;
	wire pslverr;

	integer seed;
	logic [31:0] model_regs [16];
	logic [31:0] prog [$];

	core_top i_core_top (
		.clk_i(clk),
		.rst_i(rst),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.paddr_i(paddr),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr)
	);

	bind core_top core_properties i_core_properties (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pready_i(pready_o),
		.pslverr_i(pslverr_o),
		.run_i(run),
		.wr_en_i(wr_en),
		.halted_i(i_apb_host_port.halted)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	task automatic stop_with_fail(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			stop_with_fail($sformatf("mismatch at %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		err = pslverr;
		check_eq(pready, 1'b1, "pready in write access phase");
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk); // prdata settled mid access phase
		data = prdata;
		err = pslverr;
		check_eq(pready, 1'b1, "pready in read access phase");
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] alu_word(input logic [3:0] op, input logic [3:0] ra,
		input logic [3:0] rb, input logic [3:0] rc);
		return {4'h0, op, ra, rb, rc, 12'h000};
	endfunction

	function automatic logic [31:0] ldi_word(input logic [3:0] ra, input logic [15:0] imm);
		return {4'h1, 4'h0, ra, 4'h0, imm};
	endfunction

	function automatic logic [31:0] mov_word(input logic [3:0] ra, input logic [3:0] rb);
		return {4'h2, 4'h0, ra, rb, 16'h0000};
	endfunction

	// biased toward reading the register just written
	function automatic logic [31:0] random_instr(input logic [3:0] last);
		int kind;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [31:0] bits;
		kind = rand_below(10);
		ra = 4'(rand_below(16));
		rb = (rand_below(2) == 0) ? last : 4'(rand_below(16));
		rc = (rand_below(2) == 0) ? last : 4'(rand_below(16));
		bits = $random(seed);
		if (kind < 5)
			return alu_word(4'(rand_below(8)), ra, rb, rc); // ops 5..7 are undefined
		else if (kind < 7)
			return ldi_word(ra, bits[15:0]);
		else if (kind < 9)
			return mov_word(ra, rb);
		else
			return {4'(3 + rand_below(12)), bits[27:0]}; // no-op type
	endfunction

	function automatic void model_apply(input logic [31:0] ir);
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] r;
		b = model_regs[ir[19:16]];
		c = model_regs[ir[15:12]];
		case (ir[31:28])
			4'h0:
			begin
				case (ir[27:24])
					4'h0: r = b + c;
					4'h1: r = b - c;
					4'h2: r = b & c;
					4'h3: r = b | c;
					4'h4: r = b ^ c;
					default: r = 32'h0;
				endcase
				model_regs[ir[23:20]] = r;
			end
			4'h1:
				model_regs[ir[23:20]] = {16'h0000, ir[15:0]};
			4'h2:
				model_regs[ir[23:20]] = b;
			default:
				; // halt and no-ops
		endcase
	endfunction

	// everything from the halt on is ignored
	function automatic void model_run_program();
		bit stopped;
		stopped = 1'b0;
		foreach (prog[i])
		begin
			if (prog[i] == HALT_WORD)
				stopped = 1'b1;
			if (!stopped)
				model_apply(prog[i]);
		end
	endfunction

	task automatic build_random_program(input int body_len);
		logic [3:0] last;
		logic [31:0] w;
		prog.delete();
		last = 4'h0;
		for (int i = 0; i < body_len; i++)
		begin
			w = random_instr(last);
			prog.push_back(w);
			last = w[23:20];
		end
		prog.push_back(HALT_WORD);
		for (int i = 0; i < 3; i++)
			prog.push_back(ldi_word(4'(rand_below(16)), 16'($random(seed))));
	endtask

	task automatic load_program();
		logic err;
		foreach (prog[i])
		begin
			apb_write(core_pkg::ADDR_IMEM_BASE + 12'(i * 4), prog[i], err);
			check_eq(err, 1'b0, "pslverr on program load");
		end
	endtask

	task automatic wait_halted();
		int waited;
		logic [31:0] status;
		logic err;
		waited = 0;
		status = 32'h0;
		while (status[1] !== 1'b1)
		begin
			if (waited >= 2000)
				stop_with_fail("timeout: core did not halt within 2000 cycles");
			else
			begin
				apb_read(core_pkg::ADDR_STATUS, status, err);
				waited += 3;
			end
		end
		check_eq(status, 32'h2, "status after halt");
	endtask

	task automatic compare_regs(input string tag);
		logic [31:0] val;
		logic err;
		for (int r = 0; r < 16; r++)
		begin
			apb_read(core_pkg::ADDR_REG_BASE + 12'(r * 4), val, err);
			check_eq(err, 1'b0, $sformatf("%s pslverr on r%0d", tag, r));
			check_eq(val, model_regs[r], $sformatf("%s r%0d", tag, r));
		end
	endtask

	task automatic start_core();
		logic err;
		apb_write(core_pkg::ADDR_CTRL, 32'h1, err);
		check_eq(err, 1'b0, "pslverr on start");
	endtask

	task automatic run_and_compare(input string tag);
		start_core();
		wait_halted();
		model_run_program();
		compare_regs(tag);
	endtask

	initial
	begin
		logic [31:0] val;
		logic err;
		seed = 32'hb58c5b07;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 12'h000;
		pwdata = 32'h0;
		for (int r = 0; r < 16; r++)
			model_regs[r] = 32'h0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		apb_read(core_pkg::ADDR_STATUS, val, err);
		check_eq(err, 1'b0, "pslverr on status after reset");
		check_eq(val, 32'h0, "status after reset");
		compare_regs("reset");

		// one ldi per register, one more behind the halt
		prog.delete();
		for (int r = 0; r < 16; r++)
			prog.push_back(ldi_word(4'(r), 16'($random(seed))));
		prog.push_back(HALT_WORD);
		prog.push_back(ldi_word(4'h3, 16'hbeef));
		load_program();
		run_and_compare("ldi");

		for (int n = 0; n < 20; n++)
		begin
			build_random_program(10 + rand_below(51));
			load_program();
			run_and_compare($sformatf("random %0d", n));
		end

		apb_read(core_pkg::ADDR_IMEM_BASE + 12'h010, val, err);
		check_eq(err, 1'b1, "pslverr on imem read");
		apb_read(12'h800, val, err);
		check_eq(err, 1'b1, "pslverr on unmapped read");
		apb_write(12'h800, 32'h1, err);
		check_eq(err, 1'b1, "pslverr on unmapped write");
		apb_read(12'h408, val, err);
		check_eq(err, 1'b1, "pslverr on unmapped status neighbour");

		// overwrite attempt on the last body word while the core runs
		build_random_program(60);
		load_program();
		start_core();
		apb_write(core_pkg::ADDR_IMEM_BASE + 12'(59 * 4),
			ldi_word(prog[59][23:20], ~prog[59][15:0]), err);
		check_eq(err, 1'b1, "pslverr on imem write while running");
		wait_halted();
		model_run_program();
		compare_regs("locked write");
		run_and_compare("rerun");

		if (i_core_top.i_core_properties.fail_count == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
			stop_with_fail("assertion failures reported by core_properties");
	end
endmodule

`default_nettype wire
